/* project.f */
design/umode_pkg.sv
design/retire_if.sv
design/viol_if.sv
design/retire_decoder.sv
design/priv_rule_checker.sv
design/violation_log.sv
design/umode_monitor_top.sv
dv/tb_umode_monitor.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module tb_umode_monitor -f project.f -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "No errors" ||
{ echo "simulation failed or did not pass"; exit 1; }
exit 0

/* dv/tb_umode_monitor.sv */
/*
  Directed testbench for the M/U privilege monitor.
  Inputs change on the falling clock edge; log registers are read
  over APB only after in-flight retirements have drained.
  misa is held at a legal RV32 value with U set.
*/
`timescale 1ns/10ps

module tb_umode_monitor;
  import umode_pkg::*;

  localparam int         COUNT_W    = 16;
  localparam int         CLK_PERIOD = 8;
  localparam int         NUM_TESTS  = 6;
  localparam xlen_word_t MISA_LEGAL = 32'h4010_0100;
  localparam xlen_word_t MST_MPP_M  = 32'h0000_1800;
  localparam xlen_word_t MST_MPP_S  = 32'h0000_0800;
  localparam xlen_word_t MST_MPRV   = 32'h0002_0000;
  localparam xlen_word_t MST_TW     = 32'h0020_0000;
  // standard RV32 encodings
  localparam xlen_word_t INSN_MRET  = 32'h3020_0073;
  localparam xlen_word_t INSN_ECALL = 32'h0000_0073;
  localparam xlen_word_t INSN_WFI   = 32'h1050_0073;
  localparam xlen_word_t INSN_NOP   = 32'h0000_0013;

  logic       clk_i;
  logic       rst_n;
  logic       valid;
  priv_mode_t mode;
  xlen_word_t insn;
  logic       trap;
  exc_cause_t cause;
  logic       intr;
  xlen_word_t mstatus_rdata;
  xlen_word_t mstatus_wdata;
  xlen_word_t mstatus_wmask;
  xlen_word_t misa_rdata;
  xlen_word_t mscratch_wmask;
  apb_addr_t  paddr;
  logic       psel;
  logic       penable;
  logic       pwrite;
  xlen_word_t pwdata;
  xlen_word_t prdata;
  logic       pready;
  logic       pslverr;
  logic       irq;

  int          errors;
  int          checks;
  logic [31:0] rng_state;

  umode_monitor_top #(
    .COUNT_W (COUNT_W)
  ) dut_i (
    .clk_i          (clk_i),
    .rst_n          (rst_n),
    .valid          (valid),
    .mode           (mode),
    .insn           (insn),
    .trap           (trap),
    .cause          (cause),
    .intr           (intr),
    .mstatus_rdata  (mstatus_rdata),
    .mstatus_wdata  (mstatus_wdata),
    .mstatus_wmask  (mstatus_wmask),
    .misa_rdata     (misa_rdata),
    .mscratch_wmask (mscratch_wmask),
    .paddr          (paddr),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .irq            (irq)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // 400 clock periods per test
  initial begin
    #(NUM_TESTS * 400 * CLK_PERIOD);
    $display("timeout: tests did not finish within %0d clock periods", NUM_TESTS * 400);
    $display("Errors found");
    $finish;
  end

  task automatic check_rules(input string what, input rule_vec_t got, input rule_vec_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input string what, input logic [COUNT_W-1:0] got,
                             input logic [COUNT_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_rule_idx(input string what, input rule_idx_t got, input rule_idx_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic rule_vec_t rule_bit(input int idx);
    rule_vec_t v;
    v      = '0;
    v[idx] = 1'b1;
    return v;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  // one retirement, held for a single clock
  task automatic retire(input priv_mode_t m, input xlen_word_t word, input logic trp,
                        input exc_cause_t cs, input logic intr_in, input xlen_word_t mst,
                        input xlen_word_t scratch_mask);
    valid          = 1'b1;
    mode           = m;
    insn           = word;
    trap           = trp;
    cause          = cs;
    intr           = intr_in;
    mstatus_rdata  = mst;
    mscratch_wmask = scratch_mask;
    @(negedge clk_i);
    valid          = 1'b0;
    trap           = 1'b0;
    intr           = 1'b0;
    mscratch_wmask = '0;
  endtask

  task automatic retire_legal(input priv_mode_t m, input xlen_word_t word);
    retire(m, word, 1'b0, '0, 1'b0, (m == MODE_M) ? MST_MPP_M : '0, '0);
  endtask

  task automatic apb_write(input apb_addr_t addr, input xlen_word_t data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk_i);
    penable = 1'b1;
    @(negedge clk_i);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output xlen_word_t data, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk_i);
    penable = 1'b1;
    @(negedge clk_i);
    // access cycle has completed, bus still held
    data = prdata;
    err  = pslverr;
    check_bit("pready", pready, 1'b1);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_reg(input apb_addr_t addr, output xlen_word_t data);
    logic err;
    apb_read(addr, data, err);
    check_bit("pslverr on mapped read", err, 1'b0);
  endtask

  task automatic clear_log();
    apb_write(REG_STATUS, 32'hFFFF_FFFF);
    apb_write(REG_TOTAL, '0);
  endtask

  task automatic expect_status_and_clear(input string what, input rule_vec_t exp);
    xlen_word_t data;
    wait_cycles(3);
    read_reg(REG_STATUS, data);
    check_rules(what, data[NUM_RULES-1:0], exp);
    clear_log();
  endtask

  task automatic test_reset_values();
    xlen_word_t data;
    read_reg(REG_STATUS, data);
    check_rules("reset STATUS", data[NUM_RULES-1:0], '0);
    read_reg(REG_ENABLE, data);
    check_rules("reset ENABLE", data[NUM_RULES-1:0], '1);
    read_reg(REG_TOTAL, data);
    check_count("reset TOTAL", data[COUNT_W-1:0], '0);
    read_reg(REG_RETIRED, data);
    check_count("reset RETIRED", data[COUNT_W-1:0], '0);
    read_reg(REG_FIRST, data);
    check_rule_idx("reset FIRST", data[3:0], 4'hF);
    check_bit("reset irq", irq, 1'b0);
  endtask

  task automatic test_legal_stream();
    xlen_word_t data;
    xlen_word_t word;
    for (int i = 0; i < 40; i++) begin
      rng_state = next_random(rng_state);
      // addi with random registers and immediate
      word = {rng_state[31:15], 3'b000, rng_state[11:7], 7'b001_0011};
      retire_legal((i % 2 == 0) ? MODE_M : MODE_U, word);
    end
    wait_cycles(3);
    read_reg(REG_STATUS, data);
    check_rules("STATUS after legal stream", data[NUM_RULES-1:0], '0);
    read_reg(REG_TOTAL, data);
    check_count("TOTAL after legal stream", data[COUNT_W-1:0], '0);
    read_reg(REG_RETIRED, data);
    check_count("RETIRED after legal stream", data[COUNT_W-1:0], COUNT_W'(40));
  endtask

  task automatic test_mprv_mscratch();
    xlen_word_t data;
    clear_log();
    // MPRV set by the retiring write, the S encoding in wdata lies outside the mask
    mstatus_wdata = MST_MPRV | MST_MPP_S;
    mstatus_wmask = MST_MPRV;
    retire(MODE_U, INSN_NOP, 1'b0, '0, 1'b0, '0, 32'hFFFF_FFFF);
    mstatus_wdata = '0;
    mstatus_wmask = '0;
    wait_cycles(2);
    check_bit("irq after MPRV violation", irq, 1'b1);
    read_reg(REG_STATUS, data);
    check_rules("STATUS after MPRV violation", data[NUM_RULES-1:0],
                rule_bit(RULE_UMODE_MPRV) | rule_bit(RULE_MSCRATCH_U));
    read_reg(REG_TOTAL, data);
    check_count("TOTAL after MPRV violation", data[COUNT_W-1:0], COUNT_W'(1));
    read_reg(REG_FIRST, data);
    check_rule_idx("FIRST after MPRV violation", data[3:0], 4'd3);
    apb_write(REG_STATUS, 32'hFFFF_FFFF);
    wait_cycles(2);
    check_bit("irq after STATUS clear", irq, 1'b0);
    read_reg(REG_STATUS, data);
    check_rules("STATUS after clear", data[NUM_RULES-1:0], '0);
  endtask

  task automatic test_next_retirement();
    clear_log();
    retire(MODE_M, INSN_NOP, 1'b1, CAUSE_ILLEGAL, 1'b0, MST_MPP_M, '0);
    retire_legal(MODE_U, INSN_NOP);
    expect_status_and_clear("trap then U", rule_bit(RULE_TRAP_TO_M));
    // mret from M with MPP = U
    retire(MODE_M, INSN_MRET, 1'b0, '0, 1'b0, '0, '0);
    retire_legal(MODE_M, INSN_NOP);
    expect_status_and_clear("mret then M", rule_bit(RULE_MRET_MPP));
    retire(MODE_M, INSN_MRET, 1'b0, '0, 1'b0, '0, '0);
    retire(MODE_M, INSN_NOP, 1'b0, '0, 1'b1, MST_MPP_M, '0);
    expect_status_and_clear("mret then interrupt", '0);
  endtask

  task automatic test_umode_insns();
    clear_log();
    retire(MODE_U, INSN_MRET, 1'b0, '0, 1'b0, '0, '0);
    expect_status_and_clear("U mret untrapped", rule_bit(RULE_UMODE_PRIV_INSN));
    // each trapping record is followed by a legal M one
    retire(MODE_U, INSN_ECALL, 1'b1, CAUSE_ILLEGAL, 1'b0, '0, '0);
    retire_legal(MODE_M, INSN_NOP);
    expect_status_and_clear("U ecall cause 2", rule_bit(RULE_ECALL_U));
    retire(MODE_U, INSN_ECALL, 1'b1, CAUSE_SEC_24, 1'b0, '0, '0);
    retire_legal(MODE_M, INSN_NOP);
    expect_status_and_clear("U ecall cause 24", '0);
    retire(MODE_U, INSN_WFI, 1'b0, '0, 1'b0, MST_TW, '0);
    expect_status_and_clear("U wfi TW set", rule_bit(RULE_WFI_TW));
    retire(MODE_U, INSN_WFI, 1'b1, CAUSE_ILLEGAL, 1'b0, '0, '0);
    retire_legal(MODE_M, INSN_NOP);
    expect_status_and_clear("U wfi TW clear trapped", rule_bit(RULE_WFI_TW));
  endtask

  task automatic test_enable_and_errors();
    xlen_word_t data;
    logic       err;
    clear_log();
    apb_write(REG_ENABLE, 32'h0000_03F7);
    read_reg(REG_ENABLE, data);
    check_rules("ENABLE after write", data[NUM_RULES-1:0], 10'h3F7);
    retire(MODE_U, INSN_NOP, 1'b0, '0, 1'b0, MST_MPRV, '0);
    wait_cycles(3);
    check_bit("irq with rule 3 masked", irq, 1'b0);
    read_reg(REG_STATUS, data);
    check_rules("STATUS with rule 3 masked", data[NUM_RULES-1:0], '0);
    read_reg(REG_TOTAL, data);
    check_count("TOTAL with rule 3 masked", data[COUNT_W-1:0], '0);
    apb_write(REG_ENABLE, 32'h0000_03FF);
    apb_read(8'h20, data, err);
    check_bit("pslverr at offset 0x20", err, 1'b1);
  endtask

  initial begin
    errors         = 0;
    checks         = 0;
    rng_state      = 32'h356b_4152;
    rst_n          = 1'b0;
    valid          = 1'b0;
    mode           = MODE_M;
    insn           = '0;
    trap           = 1'b0;
    cause          = '0;
    intr           = 1'b0;
    mstatus_rdata  = '0;
    mstatus_wdata  = '0;
    mstatus_wmask  = '0;
    misa_rdata     = MISA_LEGAL;
    mscratch_wmask = '0;
    paddr          = '0;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    pwdata         = '0;
    repeat (3) @(negedge clk_i);
    rst_n = 1'b1;

    test_reset_values();
    test_legal_stream();
    test_mprv_mscratch();
    test_next_retirement();
    test_umode_insns();
    test_enable_and_errors();

    $display("checks run: %0d, failed: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* design/umode_monitor_top.sv */
/*
  Retirement-trace privilege monitor for an M/U-only RISC-V core.
  One record per cycle, no handshake; results show two cycles later
  in the registers and irq follows one cycle after that.
*/
`timescale 1ns/10ps

module umode_monitor_top #(
  parameter int COUNT_W = 16
) (
  input  logic                  clk_i,
  input  logic                  rst_n,
  // retirement trace
  input  logic                  valid,
  input  umode_pkg::priv_mode_t mode,
  input  umode_pkg::xlen_word_t insn,
  input  logic                  trap,
  input  umode_pkg::exc_cause_t cause,
  input  logic                  intr,
  input  umode_pkg::xlen_word_t mstatus_rdata,
  input  umode_pkg::xlen_word_t mstatus_wdata,
  input  umode_pkg::xlen_word_t mstatus_wmask,
  input  umode_pkg::xlen_word_t misa_rdata,
  input  umode_pkg::xlen_word_t mscratch_wmask,
  // apb slave
  input  umode_pkg::apb_addr_t  paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  umode_pkg::xlen_word_t pwdata,
  output umode_pkg::xlen_word_t prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic                  irq
);

  retire_if ret_bus ();
  viol_if   viol_bus ();

  retire_decoder decoder_i (
    .clk_i          (clk_i),
    .rst_n          (rst_n),
    .valid          (valid),
    .mode           (mode),
    .insn           (insn),
    .trap           (trap),
    .cause          (cause),
    .intr           (intr),
    .mstatus_rdata  (mstatus_rdata),
    .mstatus_wdata  (mstatus_wdata),
    .mstatus_wmask  (mstatus_wmask),
    .misa_rdata     (misa_rdata),
    .mscratch_wmask (mscratch_wmask),
    .ret            (ret_bus.src)
  );

  priv_rule_checker checker_i (
    .clk_i (clk_i),
    .rst_n (rst_n),
    .ret   (ret_bus.dst),
    .viol  (viol_bus.src)
  );

  violation_log #(
    .COUNT_W (COUNT_W)
  ) log_i (
    .clk_i   (clk_i),
    .rst_n   (rst_n),
    .viol    (viol_bus.dst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .irq     (irq)
  );

endmodule

/* design/violation_log.sv */
/*
  Violation log with APB register access.
  pready is tied high, transfers finish in the access cycle.
  Counters saturate; a write to TOTAL clears TOTAL, RETIRED and FIRST.
  STATUS is write-1-to-clear; a new violation in the same cycle wins.
*/
`timescale 1ns/10ps

module violation_log #(
  parameter int COUNT_W = 16
) (
  input  logic                  clk_i,
  input  logic                  rst_n,
  viol_if.dst                   viol,
  input  umode_pkg::apb_addr_t  paddr,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  umode_pkg::xlen_word_t pwdata,
  output umode_pkg::xlen_word_t prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic                  irq
);
  import umode_pkg::*;

  localparam rule_idx_t FIRST_NONE = 4'hF;

  rule_vec_t    status;
  rule_vec_t    enable;
  rule_vec_t    masked;
  rule_vec_t    w1c;
  logic [COUNT_W-1:0] total;
  logic [COUNT_W-1:0] retired;
  rule_idx_t    first;
  rule_idx_t    first_hit;
  logic         access;
  logic         wr;
  logic         mapped;
  logic         clr_cnt;

  assign access  = psel && penable;
  assign wr      = access && pwrite;
  assign mapped  = (paddr == REG_STATUS) || (paddr == REG_ENABLE) ||
                   (paddr == REG_TOTAL) || (paddr == REG_RETIRED) || (paddr == REG_FIRST);
  assign clr_cnt = wr && (paddr == REG_TOTAL);
  assign w1c     = (wr && (paddr == REG_STATUS)) ? pwdata[NUM_RULES-1:0] : '0;
  assign masked  = viol.valid ? (viol.viol & enable) : '0;

  assign pready  = 1'b1;
  assign pslverr = access && !mapped;

  // lowest set rule index
  always_comb begin
    first_hit = FIRST_NONE;
    for (int i = NUM_RULES - 1; i >= 0; i--) begin
      if (masked[i]) begin
        first_hit = rule_idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      status  <= '0;
      enable  <= '1;
      total   <= '0;
      retired <= '0;
      first   <= FIRST_NONE;
      irq     <= 1'b0;
    end else begin
      status <= (status & ~w1c) | masked;
      irq    <= |(status & enable);
      if (wr && (paddr == REG_ENABLE)) begin
        enable <= pwdata[NUM_RULES-1:0];
      end
      if (clr_cnt) begin
        total   <= '0;
        retired <= '0;
        first   <= FIRST_NONE;
      end else begin
        if (viol.valid && !(&retired)) begin
          retired <= retired + COUNT_W'(1);
        end
        if ((|masked) && !(&total)) begin
          total <= total + COUNT_W'(1);
        end
        if (first == FIRST_NONE) begin
          first <= first_hit;
        end
      end
    end
  end

  always_comb begin
    case (paddr)
      REG_STATUS:  prdata = 32'(status);
      REG_ENABLE:  prdata = 32'(enable);
      REG_TOTAL:   prdata = 32'(total);
      REG_RETIRED: prdata = 32'(retired);
      REG_FIRST:   prdata = 32'(first);
      default:     prdata = '0;
    endcase
  end

endmodule

/* design/priv_rule_checker.sv */
/*
  Combinational rule check on the registered record.
  Rules 5 and 6 look at the next valid record after a trap or an mret;
  only one such pending check is held, the latest record decides it.
  Exception causes 1, 24 and 25 outrank the illegal and ecall checks.
*/
`timescale 1ns/10ps

module priv_rule_checker (
  input  logic  clk_i,
  input  logic  rst_n,
  retire_if.dst ret,
  viol_if.src   viol
);
  import umode_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    AFTER_TRAP,
    AFTER_MRET
  } chk_state_e;

  chk_state_e state;
  priv_mode_t mret_mode;
  rule_vec_t  rules;
  logic       in_u;
  logic       hi_pri;
  logic       illegal;
  logic       ecall_trap;
  logic       priv_insn;

  assign in_u       = (ret.mode == MODE_U);
  assign hi_pri     = ret.trap && ((ret.cause == CAUSE_INSTR_FAULT) ||
                                   (ret.cause == CAUSE_SEC_24) ||
                                   (ret.cause == CAUSE_SEC_25));
  assign illegal    = ret.trap && (ret.cause == CAUSE_ILLEGAL);
  assign ecall_trap = ret.trap && (ret.cause == CAUSE_ECALL_U);
  assign priv_insn  = ret.is_mret || ret.is_uret || ret.is_custom || ret.is_csr_priv;

  always_comb begin
    rules = '0;
    if (ret.valid) begin
      rules[RULE_MODE_LEGAL] = (ret.mode != MODE_U) && (ret.mode != MODE_M);
      rules[RULE_MISA_BITS]  = !ret.misa_ok;
      rules[RULE_MPP_LEGAL]  = (ret.mpp_post != MODE_U) && (ret.mpp_post != MODE_M);
      rules[RULE_UMODE_MPRV] = in_u && ret.mprv;
      rules[RULE_MSCRATCH_U] = in_u && ret.mscratch_wr;

      // next-retirement rules
      rules[RULE_TRAP_TO_M] = (state == AFTER_TRAP) && (ret.mode != MODE_M);
      // an interrupt may preempt the mret target
      rules[RULE_MRET_MPP]  = (state == AFTER_MRET) && !ret.intr &&
                              (ret.mode != mret_mode);

      rules[RULE_UMODE_PRIV_INSN] = in_u && priv_insn && !(illegal || hi_pri);
      rules[RULE_ECALL_U]         = in_u && ret.is_ecall && !(ecall_trap || hi_pri);

      // wfi is illegal in U exactly when TW is set
      if (in_u && ret.is_wfi) begin
        if (ret.tw) begin
          rules[RULE_WFI_TW] = !(illegal || hi_pri);
        end else begin
          rules[RULE_WFI_TW] = illegal;
        end
      end
    end
  end

  // pending check for the next valid record
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      state     <= IDLE;
      mret_mode <= MODE_M;
    end else if (ret.valid) begin
      if (ret.trap) begin
        state <= AFTER_TRAP;
      end else if (ret.is_mret && (ret.mode == MODE_M)) begin
        state     <= AFTER_MRET;
        mret_mode <= ret.mpp_pre;
      end else begin
        state <= IDLE;
      end
    end
  end

  assign viol.valid = ret.valid;
  assign viol.viol  = rules;

endmodule

/* design/retire_decoder.sv */
/*
  Registers one retirement per cycle and classifies it.
  The trace has no back-pressure; every valid input is taken.
  A record with an instruction fetch fault carries no class flags,
  since its instruction word cannot be trusted.
*/
`timescale 1ns/10ps

module retire_decoder (
  input  logic                  clk_i,
  input  logic                  rst_n,
  input  logic                  valid,
  input  umode_pkg::priv_mode_t mode,
  input  umode_pkg::xlen_word_t insn,
  input  logic                  trap,
  input  umode_pkg::exc_cause_t cause,
  input  logic                  intr,
  input  umode_pkg::xlen_word_t mstatus_rdata,
  input  umode_pkg::xlen_word_t mstatus_wdata,
  input  umode_pkg::xlen_word_t mstatus_wmask,
  input  umode_pkg::xlen_word_t misa_rdata,
  input  umode_pkg::xlen_word_t mscratch_wmask,
  retire_if.src                 ret
);
  import umode_pkg::*;

  // fixed system instruction encodings
  localparam xlen_word_t MRET_INSN   = 32'h3020_0073;
  localparam xlen_word_t URET_INSN   = 32'h0020_0073;
  localparam xlen_word_t ECALL_INSN  = 32'h0000_0073;
  localparam xlen_word_t WFI_INSN    = 32'h1050_0073;
  localparam xlen_word_t CUSTOM_MASK = 32'hFC00_707F;
  localparam xlen_word_t CUSTOM0_VAL = 32'h8C00_0073;
  localparam xlen_word_t CUSTOM1_VAL = 32'hCC00_0073;
  localparam logic [6:0] OPC_SYSTEM  = 7'b111_0011;

  logic       revoked;
  logic       csr_insn;
  xlen_word_t mstatus_post;

  assign revoked = trap && (cause == CAUSE_INSTR_FAULT);

  // funct3 of 0 is the privileged group, 4 is reserved
  assign csr_insn = (insn[6:0] == OPC_SYSTEM) &&
                    (insn[14:12] != 3'd0) &&
                    (insn[14:12] != 3'd4);

  // written bits take wdata, the rest keep their old value
  assign mstatus_post = (mstatus_wdata & mstatus_wmask) |
                        (mstatus_rdata & ~mstatus_wmask);

  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      ret.valid <= 1'b0;
    end else begin
      ret.valid <= valid;
    end
  end

  always_ff @(posedge clk_i) begin
    ret.mode  <= mode;
    ret.intr  <= intr;
    ret.trap  <= trap;
    ret.cause <= cause;

    ret.is_mret   <= !revoked && (insn == MRET_INSN);
    ret.is_uret   <= !revoked && (insn == URET_INSN);
    ret.is_ecall  <= !revoked && (insn == ECALL_INSN);
    ret.is_wfi    <= !revoked && (insn == WFI_INSN);
    ret.is_custom <= !revoked && (((insn & CUSTOM_MASK) == CUSTOM0_VAL) ||
                                  ((insn & CUSTOM_MASK) == CUSTOM1_VAL));
    // csr address bits 29:28 give the lowest privilege allowed
    ret.is_csr_priv <= !revoked && csr_insn && (insn[29:28] != MODE_U);

    ret.mpp_pre     <= mstatus_rdata[MPP_POS +: 2];
    ret.mpp_post    <= mstatus_post[MPP_POS +: 2];
    ret.mprv        <= mstatus_post[MPRV_POS];
    ret.tw          <= mstatus_post[TW_POS];
    ret.misa_ok     <= misa_rdata[MISA_U_POS] && !misa_rdata[MISA_S_POS] &&
                       !misa_rdata[MISA_N_POS];
    ret.mscratch_wr <= |mscratch_wmask;
  end

endmodule

/* design/viol_if.sv */
/*
  Per-retirement violation vector, unmasked.
  viol is only meaningful while valid is high.
*/
`timescale 1ns/10ps

interface viol_if;
  import umode_pkg::*;

  logic      valid;
  rule_vec_t viol;

  modport src (output valid, viol);
  modport dst (input valid, viol);

endinterface

/* design/retire_if.sv */
/*
  Classified retirement record, one per cycle at most.
  Class flags are already cleared for fetch-faulted records.
*/
`timescale 1ns/10ps

interface retire_if;
  import umode_pkg::*;

  logic       valid;
  priv_mode_t mode;
  logic       intr;
  logic       trap;
  exc_cause_t cause;
  // instruction class
  logic       is_mret;
  logic       is_uret;
  logic       is_custom;
  logic       is_ecall;
  logic       is_wfi;
  logic       is_csr_priv;
  // csr state seen at retirement
  priv_mode_t mpp_pre;
  priv_mode_t mpp_post;
  logic       mprv;
  logic       tw;
  logic       misa_ok;
  logic       mscratch_wr;

  modport src (output valid, mode, intr, trap, cause, is_mret, is_uret, is_custom, is_ecall,
               is_wfi, is_csr_priv, mpp_pre, mpp_post, mprv, tw, misa_ok, mscratch_wr);
  modport dst (input valid, mode, intr, trap, cause, is_mret, is_uret, is_custom, is_ecall,
               is_wfi, is_csr_priv, mpp_pre, mpp_post, mprv, tw, misa_ok, mscratch_wr);

endinterface

/* design/umode_pkg.sv */
/*
  Shared types and constants for the M/U privilege monitor.
  Only machine and user mode exist; supervisor encodings are illegal.
  Field positions follow the RV32 privileged spec layout.
*/
package umode_pkg;

  typedef logic [1:0]  priv_mode_t;
  typedef logic [31:0] xlen_word_t;
  typedef logic [5:0]  exc_cause_t;
  typedef logic [7:0]  apb_addr_t;

  localparam priv_mode_t MODE_U = 2'd0;
  localparam priv_mode_t MODE_M = 2'd3;

  localparam exc_cause_t CAUSE_INSTR_FAULT = 6'd1;
  localparam exc_cause_t CAUSE_ILLEGAL     = 6'd2;
  localparam exc_cause_t CAUSE_ECALL_U     = 6'd8;
  localparam exc_cause_t CAUSE_SEC_24      = 6'd24;
  localparam exc_cause_t CAUSE_SEC_25      = 6'd25;

  localparam int NUM_RULES = 10;

  typedef logic [NUM_RULES-1:0] rule_vec_t;
  typedef logic [3:0]           rule_idx_t;

  // bit positions in the violation vector
  localparam int RULE_MODE_LEGAL      = 0;
  localparam int RULE_MISA_BITS       = 1;
  localparam int RULE_MPP_LEGAL       = 2;
  localparam int RULE_UMODE_MPRV      = 3;
  localparam int RULE_MSCRATCH_U      = 4;
  localparam int RULE_TRAP_TO_M       = 5;
  localparam int RULE_MRET_MPP        = 6;
  localparam int RULE_UMODE_PRIV_INSN = 7;
  localparam int RULE_ECALL_U         = 8;
  localparam int RULE_WFI_TW          = 9;

  // mstatus and misa fields
  localparam int MPP_POS    = 11;
  localparam int MPRV_POS   = 17;
  localparam int TW_POS     = 21;
  localparam int MISA_U_POS = 20;
  localparam int MISA_S_POS = 18;
  localparam int MISA_N_POS = 13;

  // register map
  localparam apb_addr_t REG_STATUS  = 8'h00;
  localparam apb_addr_t REG_ENABLE  = 8'h04;
  localparam apb_addr_t REG_TOTAL   = 8'h08;
  localparam apb_addr_t REG_RETIRED = 8'h0C;
  localparam apb_addr_t REG_FIRST   = 8'h10;

endpackage
